//--- src/daq_pkg.sv
package daq_pkg;

    localparam int DATA_WIDTH   = 32;  // Register width
    localparam int REG_COUNT    = 16;
    localparam int ADDR_WIDTH   = 4;
    localparam int SAMPLE_WIDTH = 16;  // One DAC sample
    localparam int BATCH_SIZE   = 4;   // Samples per batch
    localparam int BURST_WIDTH  = 8;
    localparam int SCALE_WIDTH  = 5;   // Holds 0 to 16
    localparam int TS_WIDTH     = 2 * DATA_WIDTH;

    // Register identifiers, value is the address
    typedef enum logic [ADDR_WIDTH-1:0] {
        RST        = 4'd0,   // Polled by RTL
        HALT       = 4'd1,
        BURST_SIZE = 4'd2,
        SCALE      = 4'd3,
        TRIG       = 4'd4,
        TS_LO      = 4'd5,   // Processor read only
        TS_HI      = 4'd6,
        TS_VALID   = 4'd7,   // Written by RTL, read by processor
        DAC_STATUS = 4'd8,   // Bit 0 is DAC busy
        SCRATCH0   = 4'd9,
        SCRATCH1   = 4'd10,
        SCRATCH2   = 4'd11,
        SCRATCH3   = 4'd12,
        SCRATCH4   = 4'd13,
        SCRATCH5   = 4'd14,
        SCRATCH6   = 4'd15
    } reg_id_e;

    typedef enum logic [1:0] {
        IDLE_R,
        RESP_WAIT,
        RESET
    } rst_state_e;

    // Scale and burst size loaders
    typedef enum logic {
        IDLE_P,
        LOAD
    } param_state_e;

    typedef enum logic {
        IDLE_H,
        HALT_DAC
    } hlt_state_e;

    typedef enum logic [1:0] {
        IDLE_T,
        POLL_WAIT,
        CLR_FB
    } ts_state_e;

    typedef enum logic {
        IDLE_D,
        BURST
    } dac_state_e;

endpackage

//--- src/ps_reg_map.sv
`timescale 1ns/1ps

module ps_reg_map (
    input  logic                                                     ps_clk,
    input  logic                                                     ps_rst,
    input  logic                                                     wr_en,
    input  logic [daq_pkg::ADDR_WIDTH-1:0]                           wr_addr,
    input  logic [daq_pkg::DATA_WIDTH-1:0]                           wr_data,
    output logic                                                     wr_resp,
    output logic                                                     wr_err,
    input  logic                                                     rd_en,
    input  logic [daq_pkg::ADDR_WIDTH-1:0]                           rd_addr,
    output logic [daq_pkg::DATA_WIDTH-1:0]                           rd_data,
    output logic                                                     rd_valid,
    input  logic [daq_pkg::REG_COUNT-1:0]                            rtl_wr_req,
    input  logic [daq_pkg::REG_COUNT-1:0][daq_pkg::DATA_WIDTH-1:0]   rtl_wr_data,
    input  logic [daq_pkg::REG_COUNT-1:0]                            rtl_rdy,
    output logic [daq_pkg::REG_COUNT-1:0][daq_pkg::DATA_WIDTH-1:0]   reg_out,
    output logic [daq_pkg::REG_COUNT-1:0]                            fresh
);

    logic wr_accept;

    // Registers the processor may only read
    function automatic logic is_ro(input logic [daq_pkg::ADDR_WIDTH-1:0] addr);
        return addr inside {daq_pkg::TS_LO, daq_pkg::TS_HI, daq_pkg::TS_VALID,
                            daq_pkg::DAC_STATUS};
    endfunction

    // Command registers the RTL watches
    function automatic logic is_polled(input logic [daq_pkg::ADDR_WIDTH-1:0] addr);
        return addr inside {[daq_pkg::RST:daq_pkg::TRIG]};
    endfunction

    assign wr_accept = wr_en && rtl_rdy[wr_addr] && !is_ro(wr_addr);

    always_ff @(posedge ps_clk) begin
        if (ps_rst) begin
            reg_out  <= '0;
            fresh    <= '0;
            wr_resp  <= 1'b0;
            wr_err   <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            wr_resp  <= wr_en;
            wr_err   <= wr_en && !wr_accept;  // Refused write
            rd_valid <= rd_en;
            for (int i = 0; i < daq_pkg::REG_COUNT; i++) begin
                if (rtl_wr_req[i]) begin
                    reg_out[i] <= rtl_wr_data[i];  // RTL side wins
                end else if (wr_accept && wr_addr == i) begin
                    reg_out[i] <= wr_data;
                end

                if (is_polled(i[daq_pkg::ADDR_WIDTH-1:0])) begin
                    fresh[i] <= wr_accept && wr_addr == i;  // One cycle pulse
                end else if (is_ro(i[daq_pkg::ADDR_WIDTH-1:0])) begin
                    if (rtl_wr_req[i]) begin
                        fresh[i] <= 1'b1;
                    end else if (rd_en && rd_addr == i) begin
                        fresh[i] <= 1'b0;  // Processor has seen it
                    end
                end
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (rd_en) begin
            rd_data <= reg_out[rd_addr];
        end
    end

endmodule

//--- src/sys_ctrl.sv
`timescale 1ns/1ps

module sys_ctrl (
    input  logic                                                     ps_clk,
    input  logic                                                     ps_rst,
    input  logic                                                     wr_resp,
    input  logic [daq_pkg::REG_COUNT-1:0][daq_pkg::DATA_WIDTH-1:0]   reg_out,
    input  logic [daq_pkg::REG_COUNT-1:0]                            fresh,
    input  logic                                                     dac_busy,
    input  logic                                                     ts_wr_req,
    input  logic [daq_pkg::TS_WIDTH-1:0]                             ts_value,
    output logic [daq_pkg::REG_COUNT-1:0]                            rtl_wr_req,
    output logic [daq_pkg::REG_COUNT-1:0][daq_pkg::DATA_WIDTH-1:0]   rtl_wr_data,
    output logic [daq_pkg::REG_COUNT-1:0]                            rtl_rdy,
    output logic                                                     rst_int,
    output logic                                                     pl_rstn,
    output logic                                                     hlt_cmd,
    output logic [daq_pkg::SCALE_WIDTH-1:0]                          scale_factor,
    output logic [daq_pkg::BURST_WIDTH-1:0]                          burst_size
);

    daq_pkg::rst_state_e   rst_state;
    daq_pkg::hlt_state_e   hlt_state;
    daq_pkg::ts_state_e    ts_state;
    daq_pkg::param_state_e prm_state [2];  // 0 scale, 1 burst size
    logic [1:0]            prm_fresh;
    logic                  rst_cmd;
    logic                  ts_clr;

    assign rst_int   = ps_rst || rst_cmd;
    assign pl_rstn   = !rst_int;
    assign prm_fresh = {fresh[daq_pkg::BURST_SIZE], fresh[daq_pkg::SCALE]};

    // Processor read has cleared the flag, drop TS_VALID now
    assign ts_clr = (ts_state == daq_pkg::POLL_WAIT) && !fresh[daq_pkg::TS_VALID];

    always_comb begin
        rtl_rdy                     = '1;
        rtl_rdy[daq_pkg::RST]        = rst_state == daq_pkg::IDLE_R;
        rtl_rdy[daq_pkg::SCALE]      = prm_state[0] != daq_pkg::LOAD;
        rtl_rdy[daq_pkg::BURST_SIZE] = prm_state[1] != daq_pkg::LOAD;
        rtl_rdy[daq_pkg::TRIG]       = !dac_busy;  // No retrigger mid burst
    end

    always_comb begin
        rtl_wr_req  = '0;
        rtl_wr_data = '0;
        rtl_wr_req[daq_pkg::TS_LO]       = ts_wr_req;
        rtl_wr_data[daq_pkg::TS_LO]      = ts_value[daq_pkg::DATA_WIDTH-1:0];
        rtl_wr_req[daq_pkg::TS_HI]       = ts_wr_req;
        rtl_wr_data[daq_pkg::TS_HI]      = ts_value[daq_pkg::TS_WIDTH-1:daq_pkg::DATA_WIDTH];
        rtl_wr_req[daq_pkg::TS_VALID]    = ts_wr_req || ts_clr;
        rtl_wr_data[daq_pkg::TS_VALID]   = {{(daq_pkg::DATA_WIDTH-1){1'b0}}, ts_wr_req};
        rtl_wr_req[daq_pkg::DAC_STATUS]  = 1'b1;  // Refreshed every cycle
        rtl_wr_data[daq_pkg::DAC_STATUS] = {{(daq_pkg::DATA_WIDTH-1){1'b0}}, dac_busy};
    end

    always_ff @(posedge ps_clk) begin
        if (rst_int) begin
            rst_cmd      <= 1'b0;
            hlt_cmd      <= 1'b0;
            scale_factor <= '0;
            burst_size   <= '0;
            rst_state    <= daq_pkg::IDLE_R;
            hlt_state    <= daq_pkg::IDLE_H;
            ts_state     <= daq_pkg::IDLE_T;
            prm_state[0] <= daq_pkg::IDLE_P;
            prm_state[1] <= daq_pkg::IDLE_P;
        end else begin
            rst_cmd <= 1'b0;

            case (rst_state)
                daq_pkg::IDLE_R: begin
                    if (fresh[daq_pkg::RST]) rst_state <= daq_pkg::RESP_WAIT;
                end
                daq_pkg::RESP_WAIT: begin
                    if (!wr_resp) rst_state <= daq_pkg::RESET;  // Response has gone out
                end
                daq_pkg::RESET: begin
                    rst_cmd   <= 1'b1;
                    rst_state <= daq_pkg::IDLE_R;
                end
                default: rst_state <= daq_pkg::IDLE_R;
            endcase

            case (hlt_state)
                daq_pkg::IDLE_H: begin
                    hlt_cmd <= 1'b0;
                    if (fresh[daq_pkg::HALT]) hlt_state <= daq_pkg::HALT_DAC;
                end
                default: begin
                    hlt_cmd   <= 1'b1;  // One cycle pulse toward the batcher
                    hlt_state <= daq_pkg::IDLE_H;
                end
            endcase

            for (int j = 0; j < 2; j++) begin
                if (prm_state[j] == daq_pkg::IDLE_P) begin
                    if (prm_fresh[j]) prm_state[j] <= daq_pkg::LOAD;
                end else begin
                    prm_state[j] <= daq_pkg::IDLE_P;
                end
            end
            if (prm_state[0] == daq_pkg::LOAD) begin
                scale_factor <= reg_out[daq_pkg::SCALE][daq_pkg::SCALE_WIDTH-1:0];
            end
            if (prm_state[1] == daq_pkg::LOAD) begin
                burst_size <= reg_out[daq_pkg::BURST_SIZE][daq_pkg::BURST_WIDTH-1:0];
            end

            case (ts_state)
                daq_pkg::IDLE_T: begin
                    // Only a fresh 1 needs clearing
                    if (fresh[daq_pkg::TS_VALID] && reg_out[daq_pkg::TS_VALID][0]) begin
                        ts_state <= daq_pkg::POLL_WAIT;
                    end
                end
                daq_pkg::POLL_WAIT: begin
                    if (ts_clr) ts_state <= daq_pkg::CLR_FB;
                end
                default: ts_state <= daq_pkg::IDLE_T;
            endcase
        end
    end

endmodule

//--- src/dac_batcher.sv
`timescale 1ns/1ps

module dac_batcher (
    input  logic                                                       ps_clk,
    input  logic                                                       ps_rst,
    input  logic                                                       trig_fresh,
    input  logic                                                       dac_rdy,
    input  logic                                                       hlt_cmd,
    input  logic [daq_pkg::SCALE_WIDTH-1:0]                            scale_factor,
    input  logic [daq_pkg::BURST_WIDTH-1:0]                            burst_size,
    output logic                                                       dac_busy,
    output logic [daq_pkg::BATCH_SIZE-1:0][daq_pkg::SAMPLE_WIDTH-1:0]  dac_batch,
    output logic                                                       valid_dac_batch
);

    daq_pkg::dac_state_e                                       state;
    logic [daq_pkg::BURST_WIDTH-1:0]                           batch_idx;
    logic [daq_pkg::BURST_WIDTH:0]                             batch_cnt_next;
    logic                                                      last_batch;
    logic                                                      emit;
    logic [daq_pkg::BATCH_SIZE-1:0][daq_pkg::SAMPLE_WIDTH-1:0] next_batch;

    assign dac_busy       = state == daq_pkg::BURST;
    assign emit           = dac_busy && dac_rdy && !hlt_cmd;
    assign batch_cnt_next = batch_idx + 1'b1;
    assign last_batch     = batch_cnt_next >= {1'b0, burst_size};  // Also catches a shrunk size

    // Ramp value b*BATCH_SIZE+k, wrapped to sample width, then scaled
    always_comb begin
        logic [daq_pkg::DATA_WIDTH-1:0] ramp;
        for (int k = 0; k < daq_pkg::BATCH_SIZE; k++) begin
            ramp          = batch_idx * daq_pkg::BATCH_SIZE + k;
            next_batch[k] = ramp[daq_pkg::SAMPLE_WIDTH-1:0] >> scale_factor;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (ps_rst) begin
            state           <= daq_pkg::IDLE_D;
            batch_idx       <= '0;
            valid_dac_batch <= 1'b0;
        end else begin
            valid_dac_batch <= emit;
            case (state)
                daq_pkg::IDLE_D: begin
                    batch_idx <= '0;
                    if (trig_fresh && burst_size != '0) state <= daq_pkg::BURST;
                end
                daq_pkg::BURST: begin
                    if (hlt_cmd) begin
                        state <= daq_pkg::IDLE_D;  // Abort
                    end else if (dac_rdy) begin
                        batch_idx <= batch_idx + 1'b1;
                        if (last_batch) state <= daq_pkg::IDLE_D;
                    end
                end
                default: state <= daq_pkg::IDLE_D;
            endcase
        end
    end

    always_ff @(posedge ps_clk) begin
        if (emit) begin
            dac_batch <= next_batch;
        end
    end

endmodule

//--- src/buff_timestamp.sv
`timescale 1ns/1ps

module buff_timestamp (
    input  logic                          ps_clk,
    input  logic                          ps_rst,
    input  logic                          trig_in,
    output logic                          ts_wr_req,
    output logic [daq_pkg::TS_WIDTH-1:0]  ts_value
);

    logic [daq_pkg::TS_WIDTH-1:0] timer;  // Cycles since reset release

    always_ff @(posedge ps_clk) begin
        if (ps_rst) begin
            timer     <= '0;
            ts_wr_req <= 1'b0;
        end else begin
            timer     <= timer + 1'b1;
            ts_wr_req <= trig_in;
        end
    end

    // Value seen in the cycle trig_in is sampled
    always_ff @(posedge ps_clk) begin
        if (trig_in && !ps_rst) begin
            ts_value <= timer;
        end
    end

endmodule

//--- src/daq_sys.sv
`timescale 1ns/1ps

module daq_sys (
    input  logic                                                       ps_clk,
    input  logic                                                       ps_rst,
    input  logic                                                       wr_en,
    input  logic [daq_pkg::ADDR_WIDTH-1:0]                             wr_addr,
    input  logic [daq_pkg::DATA_WIDTH-1:0]                             wr_data,
    output logic                                                       wr_resp,
    output logic                                                       wr_err,
    input  logic                                                       rd_en,
    input  logic [daq_pkg::ADDR_WIDTH-1:0]                             rd_addr,
    output logic [daq_pkg::DATA_WIDTH-1:0]                             rd_data,
    output logic                                                       rd_valid,
    input  logic                                                       dac_rdy,
    input  logic                                                       trig_in,
    output logic [daq_pkg::BATCH_SIZE-1:0][daq_pkg::SAMPLE_WIDTH-1:0]  dac_batch,
    output logic                                                       valid_dac_batch,
    output logic                                                       pl_rstn
);

    logic [daq_pkg::REG_COUNT-1:0][daq_pkg::DATA_WIDTH-1:0] reg_out;
    logic [daq_pkg::REG_COUNT-1:0][daq_pkg::DATA_WIDTH-1:0] rtl_wr_data;
    logic [daq_pkg::REG_COUNT-1:0]                          fresh;
    logic [daq_pkg::REG_COUNT-1:0]                          rtl_wr_req;
    logic [daq_pkg::REG_COUNT-1:0]                          rtl_rdy;
    logic [daq_pkg::SCALE_WIDTH-1:0]                        scale_factor;
    logic [daq_pkg::BURST_WIDTH-1:0]                        burst_size;
    logic [daq_pkg::TS_WIDTH-1:0]                           ts_value;
    logic                                                   rst_int;  // External or soft reset
    logic                                                   hlt_cmd;
    logic                                                   dac_busy;
    logic                                                   ts_wr_req;

    ps_reg_map u_reg_map (
        .ps_clk      (ps_clk),
        .ps_rst      (rst_int),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_resp     (wr_resp),
        .wr_err      (wr_err),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .rtl_wr_req  (rtl_wr_req),
        .rtl_wr_data (rtl_wr_data),
        .rtl_rdy     (rtl_rdy),
        .reg_out     (reg_out),
        .fresh       (fresh)
    );

    sys_ctrl u_ctrl (
        .ps_clk       (ps_clk),
        .ps_rst       (ps_rst),
        .wr_resp      (wr_resp),
        .reg_out      (reg_out),
        .fresh        (fresh),
        .dac_busy     (dac_busy),
        .ts_wr_req    (ts_wr_req),
        .ts_value     (ts_value),
        .rtl_wr_req   (rtl_wr_req),
        .rtl_wr_data  (rtl_wr_data),
        .rtl_rdy      (rtl_rdy),
        .rst_int      (rst_int),
        .pl_rstn      (pl_rstn),
        .hlt_cmd      (hlt_cmd),
        .scale_factor (scale_factor),
        .burst_size   (burst_size)
    );

    dac_batcher u_dac (
        .ps_clk          (ps_clk),
        .ps_rst          (rst_int),
        .trig_fresh      (fresh[daq_pkg::TRIG]),
        .dac_rdy         (dac_rdy),
        .hlt_cmd         (hlt_cmd),
        .scale_factor    (scale_factor),
        .burst_size      (burst_size),
        .dac_busy        (dac_busy),
        .dac_batch       (dac_batch),
        .valid_dac_batch (valid_dac_batch)
    );

    buff_timestamp u_ts (
        .ps_clk    (ps_clk),
        .ps_rst    (rst_int),
        .trig_in   (trig_in),
        .ts_wr_req (ts_wr_req),
        .ts_value  (ts_value)
    );

endmodule

//--- verif/tb_daq_sys.sv
`timescale 1ns/1ps

module tb_daq_sys;

    typedef logic [daq_pkg::DATA_WIDTH-1:0] word_t;
    typedef logic [daq_pkg::ADDR_WIDTH-1:0] addr_t;
    typedef logic [daq_pkg::BATCH_SIZE-1:0][daq_pkg::SAMPLE_WIDTH-1:0] batch_t;

    typedef enum {
        OP_WRITE,     // exp holds wr_err
        OP_READ,      // exp holds read data
        OP_SCALE,
        OP_BURST,     // exp holds batch count
        OP_HALT,
        OP_STAMP,
        OP_SOFT_RST,  // exp holds pl_rstn low cycles
        OP_ZEROS
    } op_e;

    typedef struct {
        op_e   op;
        addr_t addr;
        word_t data;
        word_t exp;
        int    scale;
    } entry_t;

    logic   ps_clk;
    logic   ps_rst;
    logic   wr_en;
    addr_t  wr_addr;
    word_t  wr_data;
    logic   wr_resp;
    logic   wr_err;
    logic   rd_en;
    addr_t  rd_addr;
    word_t  rd_data;
    logic   rd_valid;
    logic   dac_rdy;
    logic   trig_in;
    batch_t dac_batch;
    logic   valid_dac_batch;
    logic   pl_rstn;

    entry_t      ops[$];
    batch_t      got_batches[$];
    int          num_ops = 0;
    int          low_cycles = 0;
    logic        rdy_random;
    logic [63:0] cycles_since_rst;  // Timestamp model

    daq_sys u_dut (
        .ps_clk          (ps_clk),
        .ps_rst          (ps_rst),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .wr_resp         (wr_resp),
        .wr_err          (wr_err),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .rd_valid        (rd_valid),
        .dac_rdy         (dac_rdy),
        .trig_in         (trig_in),
        .dac_batch       (dac_batch),
        .valid_dac_batch (valid_dac_batch),
        .pl_rstn         (pl_rstn)
    );

    initial begin
        ps_clk = 1'b0;
        forever #20 ps_clk = ~ps_clk;
    end

    always @(posedge ps_clk) begin
        if (ps_rst) begin
            cycles_since_rst <= '0;
        end else begin
            cycles_since_rst <= cycles_since_rst + 1'b1;
        end
    end

    // Mid-cycle sampling of registered outputs
    always @(negedge ps_clk) begin
        if (valid_dac_batch === 1'b1) got_batches.push_back(dac_batch);
        if (ps_rst === 1'b0 && pl_rstn === 1'b0) low_cycles++;
    end

    initial begin
        logic use_rand;
        void'($urandom(89342));
        dac_rdy = 1'b0;
        forever begin
            @(posedge ps_clk);
            use_rand = rdy_random;  // Mode taken at the edge
            #2;
            dac_rdy = use_rand && ($urandom % 2 == 1);
        end
    end

    initial begin
        wait (num_ops != 0);
        repeat (num_ops * 200) @(posedge ps_clk);
        fail_run("Watchdog expired before the test table finished");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_batch(input string name, input batch_t got, input batch_t exp);
        if (got !== exp) fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    // Ramp b*BATCH_SIZE+k, wrapped to the sample width, shifted by scale
    function automatic batch_t ramp_batch(input int b, input int scale);
        batch_t      s;
        logic [31:0] v;
        for (int k = 0; k < daq_pkg::BATCH_SIZE; k++) begin
            v    = (b * daq_pkg::BATCH_SIZE + k) % (1 << daq_pkg::SAMPLE_WIDTH);
            v    = v >> scale;
            s[k] = v[daq_pkg::SAMPLE_WIDTH-1:0];
        end
        return s;
    endfunction

    task automatic next_cycle();
        @(posedge ps_clk);
        #2;
    endtask

    task automatic write_reg(input addr_t addr, input word_t data, input logic exp_err);
        int waited;
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        next_cycle();
        wr_en  = 1'b0;
        waited = 0;
        while (wr_resp !== 1'b1 && waited < 10) begin
            next_cycle();
            waited++;
        end
        if (wr_resp !== 1'b1) fail_run("No write response within 10 cycles");
        check_bit($sformatf("wr_err[%0d]", addr), wr_err, exp_err);
    endtask

    task automatic read_reg(input addr_t addr, output word_t data);
        int waited;
        rd_en   = 1'b1;
        rd_addr = addr;
        next_cycle();
        rd_en  = 1'b0;
        waited = 0;
        while (rd_valid !== 1'b1 && waited < 10) begin
            next_cycle();
            waited++;
        end
        if (rd_valid !== 1'b1) fail_run("No read data within 10 cycles");
        data = rd_data;
    endtask

    // Busy must show in DAC_STATUS and then drop
    task automatic wait_dac_idle();
        word_t status;
        logic  seen_busy;
        int    polls;
        status    = '0;
        seen_busy = 1'b0;
        polls     = 0;
        while (!(seen_busy && !status[0]) && polls < 100) begin
            read_reg(daq_pkg::DAC_STATUS, status);
            if (status[0]) seen_busy = 1'b1;
            polls++;
        end
        if (!seen_busy || status[0]) fail_run("DAC burst did not start and finish in time");
    endtask

    task automatic check_burst(input word_t exp_count, input int scale);
        check_word("batch count", word_t'(got_batches.size()), exp_count);
        for (int b = 0; b < got_batches.size(); b++) begin
            check_batch($sformatf("dac_batch[%0d]", b), got_batches[b], ramp_batch(b, scale));
        end
    endtask

    task automatic run_entry(input entry_t e);
        word_t       value;
        word_t       ts_word;
        logic [63:0] exp_ts;
        int          lows;
        int          waited;
        case (e.op)
            OP_WRITE: write_reg(e.addr, e.data, e.exp[0]);
            OP_READ: begin
                read_reg(e.addr, value);
                check_word($sformatf("rd_data[%0d]", e.addr), value, e.exp);
            end
            OP_SCALE: begin
                write_reg(daq_pkg::SCALE, e.data, 1'b0);
                next_cycle();
                read_reg(daq_pkg::SCALE, value);
                check_word("rd_data[SCALE]", value, e.exp);
            end
            OP_BURST: begin
                got_batches.delete();
                rdy_random = 1'b1;
                write_reg(daq_pkg::TRIG, 32'd1, 1'b0);
                next_cycle();
                write_reg(daq_pkg::TRIG, 32'd1, 1'b1);  // Retrigger while busy
                wait_dac_idle();
                rdy_random = 1'b0;
                check_burst(e.exp, e.scale);
            end
            OP_HALT: begin
                got_batches.delete();
                rdy_random = 1'b0;  // DAC stalled for the whole burst
                write_reg(daq_pkg::TRIG, 32'd1, 1'b0);
                write_reg(daq_pkg::HALT, 32'd1, 1'b0);
                wait_dac_idle();
                check_burst(e.exp, e.scale);
            end
            OP_STAMP: begin
                trig_in = 1'b1;
                exp_ts  = cycles_since_rst;
                next_cycle();
                trig_in = 1'b0;
                value   = '0;
                waited  = 0;
                while (value !== 32'd1 && waited < 20) begin
                    read_reg(daq_pkg::TS_VALID, value);
                    waited++;
                end
                if (value !== 32'd1) fail_run("TS_VALID never went to 1 after trig_in");
                read_reg(daq_pkg::TS_LO, ts_word);
                check_word("rd_data[TS_LO]", ts_word, exp_ts[31:0]);
                read_reg(daq_pkg::TS_HI, ts_word);
                check_word("rd_data[TS_HI]", ts_word, exp_ts[63:32]);
            end
            OP_SOFT_RST: begin
                lows       = low_cycles;
                rdy_random = 1'b0;
                write_reg(daq_pkg::TRIG, 32'd1, 1'b0);  // Stalled burst for the reset to clear
                write_reg(daq_pkg::RST, e.data, 1'b0);
                waited = 0;
                while (pl_rstn !== 1'b0 && waited < 10) begin
                    next_cycle();
                    waited++;
                end
                if (pl_rstn !== 1'b0) fail_run("Soft reset never pulled pl_rstn low");
                repeat (3) next_cycle();
                check_bit("pl_rstn", pl_rstn, 1'b1);
                check_word("pl_rstn low cycles", word_t'(low_cycles - lows), e.exp);
            end
            OP_ZEROS: begin
                for (int a = 0; a < daq_pkg::REG_COUNT; a++) begin
                    read_reg(a[daq_pkg::ADDR_WIDTH-1:0], value);
                    check_word($sformatf("rd_data[%0d]", a), value, e.exp);
                end
            end
            default: fail_run("Unknown operation in the test table");
        endcase
    endtask

    task automatic add_op(input op_e op, input addr_t addr, input word_t data,
                          input word_t exp, input int scale);
        entry_t e;
        e.op    = op;
        e.addr  = addr;
        e.data  = data;
        e.exp   = exp;
        e.scale = scale;
        ops.push_back(e);
    endtask

    task automatic build_table();
        add_op(OP_WRITE, daq_pkg::SCRATCH0, 32'ha5a5_0001, 32'd0, 0);
        add_op(OP_READ, daq_pkg::SCRATCH0, '0, 32'ha5a5_0001, 0);
        add_op(OP_WRITE, daq_pkg::SCRATCH6, 32'hdead_beef, 32'd0, 0);
        add_op(OP_READ, daq_pkg::SCRATCH6, '0, 32'hdead_beef, 0);
        add_op(OP_WRITE, daq_pkg::HALT, 32'd1, 32'd0, 0);
        add_op(OP_READ, daq_pkg::HALT, '0, 32'd1, 0);
        add_op(OP_WRITE, daq_pkg::TS_LO, 32'h1234, 32'd1, 0);  // Read-only group
        add_op(OP_WRITE, daq_pkg::TS_HI, 32'h5678, 32'd1, 0);
        add_op(OP_WRITE, daq_pkg::TS_VALID, 32'd1, 32'd1, 0);
        add_op(OP_WRITE, daq_pkg::DAC_STATUS, 32'hffff, 32'd1, 0);
        add_op(OP_READ, daq_pkg::TS_LO, '0, 32'd0, 0);
        add_op(OP_READ, daq_pkg::TS_HI, '0, 32'd0, 0);
        add_op(OP_READ, daq_pkg::DAC_STATUS, '0, 32'd0, 0);
        add_op(OP_WRITE, daq_pkg::BURST_SIZE, 32'd3, 32'd0, 0);
        add_op(OP_READ, daq_pkg::BURST_SIZE, '0, 32'd3, 0);
        add_op(OP_SCALE, daq_pkg::SCALE, 32'd2, 32'd2, 0);
        add_op(OP_BURST, daq_pkg::TRIG, '0, 32'd3, 2);
        add_op(OP_HALT, daq_pkg::TRIG, '0, 32'd0, 2);
        add_op(OP_READ, daq_pkg::DAC_STATUS, '0, 32'd0, 0);
        add_op(OP_STAMP, daq_pkg::TS_LO, '0, '0, 0);
        add_op(OP_READ, daq_pkg::TS_VALID, '0, 32'd0, 0);
        add_op(OP_WRITE, daq_pkg::SCRATCH3, 32'h55, 32'd0, 0);
        add_op(OP_SOFT_RST, daq_pkg::RST, 32'd1, 32'd1, 0);
        add_op(OP_ZEROS, daq_pkg::RST, '0, 32'd0, 0);
        add_op(OP_WRITE, daq_pkg::BURST_SIZE, 32'd2, 32'd0, 0);
        add_op(OP_BURST, daq_pkg::TRIG, '0, 32'd2, 0);  // Scale back at 0
    endtask

    initial begin
        ps_rst     = 1'b1;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        trig_in    = 1'b0;
        rdy_random = 1'b0;
        build_table();
        num_ops = ops.size();
        repeat (5) @(posedge ps_clk);
        #2;
        ps_rst = 1'b0;
        next_cycle();
        foreach (ops[i]) begin
            run_entry(ops[i]);
            next_cycle();  // One idle cycle between entries
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- src.f
src/daq_pkg.sv
src/ps_reg_map.sv
src/sys_ctrl.sv
src/dac_batcher.sv
src/buff_timestamp.sv
src/daq_sys.sv
verif/tb_daq_sys.sv
